/* ualink_stream_pkg.sv */
// AXI4-Stream word types shared by every stream port; data width is fixed at 64 by the header format

package ualink_stream_pkg;

   // payload width of every stream word
   localparam int data_width = 64;

   // sideband carried alongside each word, passed through untouched
   localparam int tuser_width = 16;

   // one stream data word
   typedef logic [data_width-1:0] tdata_t;

   // one sideband word
   typedef logic [tuser_width-1:0] tuser_t;

endpackage

/* ualink_cmd_pkg.sv */
// command header format and RAM geometry; only the first word of a packet is decoded as a header

package ualink_cmd_pkg;

   // header opcodes, bits 15:8 of the first word
   localparam logic [7:0] opcode_write = 8'hEF; // store header word at addr
   localparam logic [7:0] opcode_read  = 8'hEE; // return stored word after header

   // address comes from the header low byte, so 256 words
   localparam int ram_addr_width = 8;

   typedef logic [ram_addr_width-1:0] ram_addr_t;

   // one 64-bit word seen either raw or as header fields
   typedef union packed {
      ualink_stream_pkg::tdata_t raw; // stored to and returned from the RAM
      struct packed {
         logic [47:0] payload;
         logic [7:0]  opcode;
         ram_addr_t   addr;
      } f;
   } cmd_header_u;

endpackage

/* ingress_fifo.sv */
// fall-through FIFO of 2**FIFO_DEPTH_BITS words; writes while nearly_full are dropped, pops while empty are ignored
`timescale 1ns/10ps

module ingress_fifo #(
   parameter int FIFO_DEPTH_BITS = 3
) (
   input  logic                      axi_aclk,
   input  logic                      axi_resetn,
   input  ualink_stream_pkg::tdata_t wr_data,
   input  ualink_stream_pkg::tuser_t wr_user,
   input  logic                      wr_last,
   input  logic                      wr_en,
   input  logic                      pop,
   output ualink_stream_pkg::tdata_t head_data,
   output ualink_stream_pkg::tuser_t head_user,
   output logic                      head_last,
   output logic                      empty,
   output logic                      nearly_full
);

   localparam int depth = 2 ** FIFO_DEPTH_BITS;

   ualink_stream_pkg::tdata_t data_mem [depth];
   ualink_stream_pkg::tuser_t user_mem [depth];
   logic                      last_mem [depth];

   logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
   logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
   logic [FIFO_DEPTH_BITS:0]   count; // one extra bit to hold depth itself
   logic                       do_wr;
   logic                       do_pop;

   assign do_wr  = wr_en & ~nearly_full;
   assign do_pop = pop & ~empty;

   assign empty       = (count == '0);
   assign nearly_full = (count >= (FIFO_DEPTH_BITS + 1)'(depth - 1));

   // head shows without a read delay
   assign head_data = data_mem[rd_ptr];
   assign head_user = user_mem[rd_ptr];
   assign head_last = last_mem[rd_ptr];

   always_ff @(posedge axi_aclk) begin
      if (do_wr) begin
         data_mem[wr_ptr] <= wr_data;
         user_mem[wr_ptr] <= wr_user;
         last_mem[wr_ptr] <= wr_last;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1; // wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_wr && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_wr)
            count <= count - 1'b1;
      end
   end

endmodule

/* queue_arbiter.sv */
// packet-locked round-robin over NUM_QUEUES queues; a packet is never interleaved, a stalled queue stalls the port
`timescale 1ns/10ps

module queue_arbiter #(
   parameter int NUM_QUEUES = 2
) (
   input  logic                      axi_aclk,
   input  logic                      axi_resetn,
   input  ualink_stream_pkg::tdata_t head_data [NUM_QUEUES],
   input  ualink_stream_pkg::tuser_t head_user [NUM_QUEUES],
   input  logic [NUM_QUEUES-1:0]     head_last,
   input  logic [NUM_QUEUES-1:0]     empty,
   input  logic                      sel_pop,
   output logic [NUM_QUEUES-1:0]     pop,
   output ualink_stream_pkg::tdata_t sel_data,
   output ualink_stream_pkg::tuser_t sel_user,
   output logic                      sel_last,
   output logic                      sel_valid,
   output logic                      sel_first
);

   // index needs at least one bit even for a single queue
   localparam int qw = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;

   logic [qw-1:0] cur_queue;
   logic [qw-1:0] next_queue;
   logic          locked; // header already popped, packet in flight

   assign next_queue = (cur_queue == qw'(NUM_QUEUES - 1)) ? '0 : cur_queue + 1'b1;

   // selected head follows the current queue with no delay
   assign sel_data  = head_data[cur_queue];
   assign sel_user  = head_user[cur_queue];
   assign sel_last  = head_last[cur_queue];
   assign sel_valid = ~empty[cur_queue];
   assign sel_first = ~locked; // first word seen while unlocked is a header

   // only the current queue ever sees a pop
   always_comb begin
      pop            = '0;
      pop[cur_queue] = sel_pop;
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         cur_queue <= '0;
         locked    <= 1'b0;
      end else if (sel_pop) begin
         if (sel_last) begin
            // packet done, give the next queue a turn
            locked    <= 1'b0;
            cur_queue <= next_queue;
         end else begin
            locked <= 1'b1;
         end
      end else if (!locked && empty[cur_queue]) begin
         cur_queue <= next_queue; // skip idle queue, one per cycle
      end
   end

endmodule

/* command_engine.sv */
// decodes only the first word of a packet; EF stores the header word, EE appends the stored word after the header
`timescale 1ns/10ps

module command_engine (
   input  logic                      axi_aclk,
   input  logic                      axi_resetn,
   input  ualink_stream_pkg::tdata_t sel_data,
   input  ualink_stream_pkg::tuser_t sel_user,
   input  logic                      sel_last,
   input  logic                      sel_valid,
   input  logic                      sel_first,
   input  logic                      m_axis_tready,
   input  ualink_stream_pkg::tdata_t rd_data,
   output logic                      sel_pop,
   output ualink_stream_pkg::tdata_t m_axis_tdata,
   output ualink_stream_pkg::tuser_t m_axis_tuser,
   output logic                      m_axis_tlast,
   output logic                      m_axis_tvalid,
   output logic                      wr_en,
   output ualink_cmd_pkg::ram_addr_t wr_addr,
   output ualink_stream_pkg::tdata_t wr_data,
   output ualink_cmd_pkg::ram_addr_t rd_addr
);

   ualink_cmd_pkg::cmd_header_u hdr; // selected word seen as a header

   logic is_hdr;
   logic is_write;
   logic is_read;
   logic handshake;   // selected word accepted downstream
   logic resp_active; // read response on the master stream

   // held for the response word
   ualink_stream_pkg::tuser_t saved_user;
   logic                      saved_last;
   ualink_cmd_pkg::ram_addr_t saved_addr;

   assign hdr.raw = sel_data;

   assign is_hdr   = sel_valid & sel_first;
   assign is_write = is_hdr & (hdr.f.opcode == ualink_cmd_pkg::opcode_write);
   assign is_read  = is_hdr & (hdr.f.opcode == ualink_cmd_pkg::opcode_read);

   // nothing leaves the queues while the response waits
   assign handshake = ~resp_active & sel_valid & m_axis_tready;
   assign sel_pop   = handshake;

   // master stream: response word or the selected word unchanged
   assign m_axis_tvalid = resp_active | sel_valid;
   assign m_axis_tdata  = resp_active ? rd_data : sel_data;
   assign m_axis_tuser  = resp_active ? saved_user : sel_user;

   // a read header never ends the packet, its tlast moves onto the response
   assign m_axis_tlast = resp_active ? saved_last : (sel_last & ~is_read);

   // write port takes the whole header word
   assign wr_en   = is_write & handshake;
   assign wr_addr = hdr.f.addr;
   assign wr_data = hdr.raw;

   // address held during the response so the registered rd_data stays put
   assign rd_addr = resp_active ? saved_addr : hdr.f.addr;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         resp_active <= 1'b0;
      end else if (resp_active) begin
         if (m_axis_tready)
            resp_active <= 1'b0; // response taken
      end else if (is_read && handshake) begin
         resp_active <= 1'b1;
      end
   end

   // capture header sideband at the read header handshake
   always_ff @(posedge axi_aclk) begin
      if (is_read && handshake) begin
         saved_user <= sel_user;
         saved_last <= sel_last;
         saved_addr <= hdr.f.addr;
      end
   end

endmodule

/* dual_port_ram.sv */
// 256 x 64 RAM, one write port and one registered read port; no reset, contents undefined until written
`timescale 1ns/10ps

module dual_port_ram (
   input  logic                      axi_aclk,
   input  logic                      wr_en,
   input  ualink_cmd_pkg::ram_addr_t wr_addr,
   input  ualink_stream_pkg::tdata_t wr_data,
   input  ualink_cmd_pkg::ram_addr_t rd_addr,
   output ualink_stream_pkg::tdata_t rd_data
);

   localparam int depth = 2 ** ualink_cmd_pkg::ram_addr_width;

   ualink_stream_pkg::tdata_t mem [depth];

   always_ff @(posedge axi_aclk) begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   // read data one cycle after the address, old word on a same-address write
   always_ff @(posedge axi_aclk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* ualink_turbo_top.sv */
// command port top; slave streams indexed by queue, tready drops at depth minus one, master obeys AXI4-Stream valid/ready
`timescale 1ns/10ps

module ualink_turbo_top #(
   parameter int NUM_QUEUES      = 2,
   parameter int FIFO_DEPTH_BITS = 3
) (
   input  logic                      axi_aclk,
   input  logic                      axi_resetn,

   // slave streams, one per queue
   input  ualink_stream_pkg::tdata_t s_axis_tdata [NUM_QUEUES],
   input  ualink_stream_pkg::tuser_t s_axis_tuser [NUM_QUEUES],
   input  logic [NUM_QUEUES-1:0]     s_axis_tlast,
   input  logic [NUM_QUEUES-1:0]     s_axis_tvalid,
   output logic [NUM_QUEUES-1:0]     s_axis_tready,

   // master stream
   output ualink_stream_pkg::tdata_t m_axis_tdata,
   output ualink_stream_pkg::tuser_t m_axis_tuser,
   output logic                      m_axis_tlast,
   output logic                      m_axis_tvalid,
   input  logic                      m_axis_tready
);

   // queue heads
   ualink_stream_pkg::tdata_t head_data [NUM_QUEUES];
   ualink_stream_pkg::tuser_t head_user [NUM_QUEUES];
   logic [NUM_QUEUES-1:0]     head_last;
   logic [NUM_QUEUES-1:0]     empty;
   logic [NUM_QUEUES-1:0]     nearly_full;
   logic [NUM_QUEUES-1:0]     pop;

   // selected queue toward the engine
   ualink_stream_pkg::tdata_t sel_data;
   ualink_stream_pkg::tuser_t sel_user;
   logic                      sel_last;
   logic                      sel_valid;
   logic                      sel_first;
   logic                      sel_pop;

   // RAM ports
   logic                      wr_en;
   ualink_cmd_pkg::ram_addr_t wr_addr;
   ualink_stream_pkg::tdata_t wr_data;
   ualink_cmd_pkg::ram_addr_t rd_addr;
   ualink_stream_pkg::tdata_t rd_data;

   for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_queue
      ingress_fifo #(
         .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
      ) u_fifo (
         .axi_aclk    (axi_aclk),
         .axi_resetn  (axi_resetn),
         .wr_data     (s_axis_tdata[i]),
         .wr_user     (s_axis_tuser[i]),
         .wr_last     (s_axis_tlast[i]),
         .wr_en       (s_axis_tvalid[i]),
         .pop         (pop[i]),
         .head_data   (head_data[i]),
         .head_user   (head_user[i]),
         .head_last   (head_last[i]),
         .empty       (empty[i]),
         .nearly_full (nearly_full[i])
      );

      assign s_axis_tready[i] = ~nearly_full[i];
   end

   queue_arbiter #(
      .NUM_QUEUES(NUM_QUEUES)
   ) u_arbiter (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .head_data  (head_data),
      .head_user  (head_user),
      .head_last  (head_last),
      .empty      (empty),
      .sel_pop    (sel_pop),
      .pop        (pop),
      .sel_data   (sel_data),
      .sel_user   (sel_user),
      .sel_last   (sel_last),
      .sel_valid  (sel_valid),
      .sel_first  (sel_first)
   );

   command_engine u_engine (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .sel_data      (sel_data),
      .sel_user      (sel_user),
      .sel_last      (sel_last),
      .sel_valid     (sel_valid),
      .sel_first     (sel_first),
      .m_axis_tready (m_axis_tready),
      .rd_data       (rd_data),
      .sel_pop       (sel_pop),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data),
      .rd_addr       (rd_addr)
   );

   dual_port_ram u_ram (
      .axi_aclk (axi_aclk),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data)
   );

endmodule

/* ualink_turbo_assertions.sv */
// stream rule checks bound into ualink_turbo_top; pop taken from the top's internal wire
`timescale 1ns/10ps

module ualink_turbo_assertions #(
   parameter int NUM_QUEUES = 2
) (
   input logic                      axi_aclk,
   input logic                      axi_resetn,
   input ualink_stream_pkg::tdata_t m_axis_tdata,
   input ualink_stream_pkg::tuser_t m_axis_tuser,
   input logic                      m_axis_tlast,
   input logic                      m_axis_tvalid,
   input logic                      m_axis_tready,
   input logic [NUM_QUEUES-1:0]     s_axis_tready,
   input logic [NUM_QUEUES-1:0]     pop
);

   // master word held with stable content until taken
   a_master_hold: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
         && $stable(m_axis_tuser) && $stable(m_axis_tlast))
      else $error("master stream word changed before ready");

   a_reset_idle: assert property (@(posedge axi_aclk)
      !axi_resetn |=> !m_axis_tvalid)
      else $error("master valid high during reset");

   // popping a full queue reopens it unless a word was taken while not ready
   for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_slave
      a_no_accept_full: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
         !s_axis_tready[i] && pop[i] |=> s_axis_tready[i])
         else $error("queue %0d accepted a word while not ready", i);
   end

endmodule

bind ualink_turbo_top ualink_turbo_assertions #(.NUM_QUEUES(NUM_QUEUES)) u_assertions (.*);

/* ualink_turbo_tb.sv */
// trace-driven testbench; expects ualink_trace.txt in the run directory and a DUT with 2 queues of 8 words
`timescale 1ns/10ps

module ualink_turbo_tb;

   localparam int num_queues      = 2;
   localparam int fifo_depth_bits = 3;
   localparam int depth           = 2 ** fifo_depth_bits;
   localparam int cycles_per_word = 200;

   logic                      axi_aclk = 1'b0;
   logic                      axi_resetn;
   ualink_stream_pkg::tdata_t s_axis_tdata [num_queues];
   ualink_stream_pkg::tuser_t s_axis_tuser [num_queues];
   logic [num_queues-1:0]     s_axis_tlast;
   logic [num_queues-1:0]     s_axis_tvalid;
   logic [num_queues-1:0]     s_axis_tready;
   ualink_stream_pkg::tdata_t m_axis_tdata;
   ualink_stream_pkg::tuser_t m_axis_tuser;
   logic                      m_axis_tlast;
   logic                      m_axis_tvalid;
   logic                      m_axis_tready;

   // trace contents
   int                        in_queue [$];
   ualink_stream_pkg::tdata_t in_data [$];
   ualink_stream_pkg::tuser_t in_user [$];
   logic                      in_last [$];
   ualink_stream_pkg::tdata_t exp_data [$];
   ualink_stream_pkg::tuser_t exp_user [$];
   logic                      exp_last [$];

   int   pushed [num_queues]; // words accepted per queue before draining starts
   logic release_bp   = 1'b0; // set once a queue is full or all words are in
   logic trace_loaded = 1'b0;

   always #10 axi_aclk = ~axi_aclk;

   ualink_turbo_top #(
      .NUM_QUEUES      (num_queues),
      .FIFO_DEPTH_BITS (fifo_depth_bits)
   ) ualink_turbo_top_i (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_tdata  (s_axis_tdata),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tlast  (s_axis_tlast),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis_tdata  (m_axis_tdata),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tlast  (m_axis_tlast),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready)
   );

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Something failed");
         $fatal(1, "value check");
      end
   endtask

   // lines are: kind queue tdata tuser tlast, kind 0 is input and 1 is expected output
   task automatic load_trace();
      int        fd;
      int        n;
      string     line;
      logic [63:0] kind;
      logic [63:0] q;
      logic [63:0] d;
      logic [63:0] u;
      logic [63:0] l;
      fd = $fopen("ualink_trace.txt", "r");
      if (fd == 0) begin
         $display("could not open the trace file ualink_trace.txt");
         $display("Something failed");
         $fatal(1, "no trace");
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#")
            continue; // blank or comment
         n = $sscanf(line, "%h %h %h %h %h", kind, q, d, u, l);
         if (n != 5) begin
            $display("trace line could not be parsed: %s", line);
            $display("Something failed");
            $fatal(1, "bad trace");
         end
         if (kind == 0) begin
            in_queue.push_back(int'(q));
            in_data.push_back(d);
            in_user.push_back(u[15:0]);
            in_last.push_back(l[0]);
         end else begin
            exp_data.push_back(d);
            exp_user.push_back(u[15:0]);
            exp_last.push_back(l[0]);
         end
      end
      $fclose(fd);
   endtask

   // feeds input words in trace order and holds each until its queue is ready
   task automatic push_words();
      int q;
      for (int i = 0; i < in_data.size(); i++) begin
         @(negedge axi_aclk);
         s_axis_tvalid = '0;
         q = in_queue[i];
         if (!release_bp)
            check_value(64'(s_axis_tready[q]), 64'(pushed[q] < depth - 1), "s_axis_tready fill");
         s_axis_tdata[q]  = in_data[i];
         s_axis_tuser[q]  = in_user[i];
         s_axis_tlast[q]  = in_last[i];
         s_axis_tvalid[q] = 1'b1;
         while (!s_axis_tready[q]) begin
            release_bp = 1'b1; // queue full, let the master drain
            @(negedge axi_aclk);
         end
         pushed[q]++;
      end
      @(negedge axi_aclk);
      s_axis_tvalid = '0;
      release_bp    = 1'b1;
   endtask

   // scoreboard on the master stream, random back-pressure once released
   task automatic drain_words();
      int idx;
      idx = 0;
      while (idx < exp_data.size()) begin
         @(negedge axi_aclk);
         m_axis_tready = release_bp ? ($urandom % 4 != 0) : 1'b0;
         #1;
         if (m_axis_tready && m_axis_tvalid) begin
            check_value(m_axis_tdata, exp_data[idx], $sformatf("tdata of word %0d", idx));
            check_value(64'(m_axis_tuser), 64'(exp_user[idx]), $sformatf("tuser of word %0d", idx));
            check_value(64'(m_axis_tlast), 64'(exp_last[idx]), $sformatf("tlast of word %0d", idx));
            idx++;
         end
      end
      @(negedge axi_aclk);
      m_axis_tready = 1'b0;
   endtask

   initial begin
      void'($urandom(32'hc171));
      axi_resetn    = 1'b0;
      s_axis_tdata  = '{default: '0};
      s_axis_tuser  = '{default: '0};
      s_axis_tlast  = '0;
      s_axis_tvalid = '0;
      m_axis_tready = 1'b0;
      pushed        = '{default: 0};
      load_trace();
      repeat (4) @(negedge axi_aclk);
      axi_resetn = 1'b1;
      trace_loaded = 1'b1;

      @(negedge axi_aclk);
      check_value(64'(m_axis_tvalid), 64'd0, "m_axis_tvalid after reset");
      check_value(64'(s_axis_tready), {64{1'b1}} >> (64 - num_queues), "s_axis_tready after reset");

      fork
         push_words();
         drain_words();
      join

      // nothing may follow the last expected word
      repeat (8) @(negedge axi_aclk);
      check_value(64'(m_axis_tvalid), 64'd0, "extra word on master stream");
      $display("Everything OK");
      $finish;
   end

   initial begin
      wait (trace_loaded);
      repeat ((in_data.size() + exp_data.size()) * cycles_per_word) @(posedge axi_aclk);
      $display("timeout: the master stream did not deliver all expected words in time");
      $display("Something failed");
      $fatal(1, "watchdog");
   end

endmodule

/* ualink_trace.txt */
# kind queue tdata tuser tlast, all hex
# kind 0 is a slave word for that queue, kind 1 an expected master word in order (queue ignored)
# queue 0: pass-through packet
0 0 1111222233331205 0001 0
0 0 a0a0a0a0a0a0a0a1 0002 0
0 0 a0a0a0a0a0a0a0a2 0003 1
# queue 0: write header at address 5a, then read it back
0 0 cafef00d1234ef5a 0102 1
0 0 000000000000ee5a 0303 1
# queue 1: two pass-through packets, eight words to fill the FIFO
0 1 bbbb000000003400 0011 0
0 1 b1b1b1b1b1b1b1b1 0012 0
0 1 b2b2b2b2b2b2b2b2 0013 0
0 1 b3b3b3b3b3b3b3b3 0014 1
0 1 dddd000000005600 0021 0
0 1 d1d1d1d1d1d1d1d1 0022 0
0 1 d2d2d2d2d2d2d2d2 0023 0
0 1 d3d3d3d3d3d3d3d3 0024 1
# expected: q0, q1, q0, q1, q0
1 0 1111222233331205 0001 0
1 0 a0a0a0a0a0a0a0a1 0002 0
1 0 a0a0a0a0a0a0a0a2 0003 1
1 0 bbbb000000003400 0011 0
1 0 b1b1b1b1b1b1b1b1 0012 0
1 0 b2b2b2b2b2b2b2b2 0013 0
1 0 b3b3b3b3b3b3b3b3 0014 1
1 0 cafef00d1234ef5a 0102 1
1 0 dddd000000005600 0021 0
1 0 d1d1d1d1d1d1d1d1 0022 0
1 0 d2d2d2d2d2d2d2d2 0023 0
1 0 d3d3d3d3d3d3d3d3 0024 1
1 0 000000000000ee5a 0303 0
1 0 cafef00d1234ef5a 0303 1

/* flist.f */
ualink_stream_pkg.sv
ualink_cmd_pkg.sv
ingress_fifo.sv
queue_arbiter.sv
command_engine.sv
dual_port_ram.sv
ualink_turbo_top.sv
ualink_turbo_assertions.sv
ualink_turbo_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module ualink_turbo_tb -o sim_tb

out=$(./obj_dir/sim_tb || true)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
   exit 0
else
   exit 1
fi
